//--- Makefile
TOOL       ?= verilator
TOP        ?= tb_stripe_sink_top
LINT_TOP   ?= stripe_sink_top
FILELIST   ?= stripe_sink_top.f
FLAGS      ?= --binary --timing -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
OBJDIR     ?= obj_dir
LOG        ?= sim.log
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qF '** PASS **' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- beat_fifo.sv
// Per-channel beat FIFO between the multiplexer and one memory channel
// Stream handshake on both sides, beats show at the output one cycle after write

`timescale 1ns/1ps

module beat_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic              aclk,
  input  logic              aresetn,

  // Write side from the multiplexer
  input  logic              s_tvalid,
  output logic              s_tready,
  input  stripe_pkg::beat_t s_beat,

  // Read side towards the memory channel
  output logic              m_tvalid,
  input  logic              m_tready,
  output stripe_pkg::beat_t m_beat
);

  localparam int PTR_BITS = $clog2(FIFO_DEPTH);
  localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

  // ------------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------------

  stripe_pkg::beat_t mem [FIFO_DEPTH];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;

  // Handshake completions
  logic wr_en;
  logic rd_en;

  assign wr_en = s_tvalid & s_tready;
  assign rd_en = m_tvalid & m_tready;

  // Ready while there is room
  assign s_tready = (count != CNT_BITS'(FIFO_DEPTH));
  // Valid while anything is held
  assign m_tvalid = (count != '0);

  // Output from the register array at the read pointer
  assign m_beat = mem[rd_ptr];

  // Payload array, no reset
  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= s_beat;
    end
  end

  // ------------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------------

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + PTR_BITS'(1);
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + PTR_BITS'(1);
      end
      // Read and write in one cycle keep the count
      case ({wr_en, rd_en})
        2'b10:   count <= count + CNT_BITS'(1);
        2'b01:   count <= count - CNT_BITS'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

//--- stripe_cmd_queue.sv
// Command queue in front of the striping multiplexer
// Head is read without latency, cmd_pop retires it at the next edge

`timescale 1ns/1ps

module stripe_cmd_queue #(
  parameter int CMD_DEPTH = 8
) (
  input  logic                    aclk,
  input  logic                    aresetn,

  // Producer side
  input  logic                    cmd_push,
  input  stripe_pkg::stripe_cmd_t cmd_in,

  // Consumer side
  input  logic                    cmd_pop,
  output stripe_pkg::stripe_cmd_t cmd_head,
  output logic                    cmd_avail,
  output logic                    cmd_full
);

  localparam int PTR_BITS = $clog2(CMD_DEPTH);
  localparam int CNT_BITS = $clog2(CMD_DEPTH + 1);

  // ------------------------------------------------------------------
  // Storage and pointers
  // ------------------------------------------------------------------

  stripe_pkg::stripe_cmd_t mem [CMD_DEPTH];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;

  logic do_push;
  logic do_pop;

  // Push into a full queue is dropped
  assign do_push = cmd_push & ~cmd_full;
  // Pop only counts while something is queued
  assign do_pop  = cmd_pop & cmd_avail;

  // Status from the occupancy counter
  assign cmd_avail = (count != '0);
  assign cmd_full  = (count == CNT_BITS'(CMD_DEPTH));

  // Head straight from the array
  assign cmd_head = mem[rd_ptr];

  // Command storage, no reset
  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= cmd_in;
    end
  end

  // Pointers wrap by overflow, depth is a power of two
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + PTR_BITS'(1);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + PTR_BITS'(1);
      end
      // Occupancy holds on simultaneous push and pop
      case ({do_push, do_pop})
        2'b10:   count <= count + CNT_BITS'(1);
        2'b01:   count <= count - CNT_BITS'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

//--- stripe_pkg.sv
// Shared widths, packed types and FSM encoding for the striping sink
// Referenced by scoped name from every RTL file and the testbench

package stripe_pkg;

  // ------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------

  // One beat of user data
  localparam int DATA_BITS = 64;
  // Byte enables for one beat
  localparam int KEEP_BITS = DATA_BITS / 8;

  // Memory channels, power of two so the index wraps by overflow
  localparam int N_CHAN    = 4;
  localparam int CHAN_BITS = $clog2(N_CHAN);

  // Command length field holds beats minus one
  localparam int LEN_BITS  = 8;

  // ------------------------------------------------------------------
  // Packed types
  // ------------------------------------------------------------------

  // Stream beat, 73 bits
  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic [KEEP_BITS-1:0] keep;
    logic                 last;
  } beat_t;

  // Stripe command, 11 bits
  typedef struct packed {
    // First channel of the stripe
    logic [CHAN_BITS-1:0] chan;
    // Beats minus one
    logic [LEN_BITS-1:0]  len;
    // Completion pulse requested
    logic                 ctl;
  } stripe_cmd_t;

  // Multiplexer FSM
  typedef enum logic [0:0] {
    ST_IDLE,
    ST_MUX
  } mux_state_t;

endpackage

//--- stripe_sink_mux.sv
// Striping multiplexer for one user stream across the channel FIFOs
// Loads a command, then sends each accepted beat to the next channel in turn

`timescale 1ns/1ps

module stripe_sink_mux (
  input  logic                                          aclk,
  input  logic                                          aresetn,

  // Command queue
  input  logic                                          cmd_avail,
  input  stripe_pkg::stripe_cmd_t                       cmd_head,
  output logic                                          cmd_pop,
  output logic                                          done,

  // User stream
  input  logic                                          s_tvalid,
  output logic                                          s_tready,
  input  stripe_pkg::beat_t                             s_beat,

  // Channel FIFOs
  output logic [stripe_pkg::N_CHAN-1:0]                 fifo_tvalid,
  input  logic [stripe_pkg::N_CHAN-1:0]                 fifo_tready,
  output stripe_pkg::beat_t [stripe_pkg::N_CHAN-1:0]    fifo_beat
);

  // ------------------------------------------------------------------
  // Registers
  // ------------------------------------------------------------------

  stripe_pkg::mux_state_t state_q, state_d;

  // Channel receiving the next beat
  logic [stripe_pkg::CHAN_BITS-1:0] sel_q, sel_d;
  // Beats left after the current one
  logic [stripe_pkg::LEN_BITS-1:0]  cnt_q, cnt_d;
  // Completion request of the running command
  logic                             ctl_q, ctl_d;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= stripe_pkg::ST_IDLE;
      sel_q   <= '0;
      cnt_q   <= '0;
      ctl_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      sel_q   <= sel_d;
      cnt_q   <= cnt_d;
      ctl_q   <= ctl_d;
    end
  end

  // ------------------------------------------------------------------
  // Datapath
  // ------------------------------------------------------------------

  logic final_beat;
  logic rxfer;
  logic tr_done;

  // Current beat closes the command
  assign final_beat = (state_q == stripe_pkg::ST_MUX) && (cnt_q == '0);

  // Beat accepted this cycle
  assign rxfer   = s_tvalid & s_tready;
  // Last beat of the command accepted
  assign tr_done = rxfer & final_beat;

  // Completion pulse only when asked for
  assign done = tr_done & ctl_q;

  // Same payload to every FIFO, user last replaced by our own
  always_comb begin
    for (int i = 0; i < stripe_pkg::N_CHAN; i++) begin
      fifo_beat[i].data = s_beat.data;
      fifo_beat[i].keep = s_beat.keep;
      fifo_beat[i].last = final_beat;
    end
  end

  // ------------------------------------------------------------------
  // FSM and routing
  // ------------------------------------------------------------------

  always_comb begin
    state_d     = state_q;
    sel_d       = sel_q;
    cnt_d       = cnt_q;
    ctl_d       = ctl_q;
    cmd_pop     = 1'b0;
    s_tready    = 1'b0;
    fifo_tvalid = '0;

    case (state_q)
      stripe_pkg::ST_IDLE: begin
        // Take the head as soon as one is queued
        if (cmd_avail) begin
          cmd_pop = 1'b1;
          sel_d   = cmd_head.chan;
          cnt_d   = cmd_head.len;
          ctl_d   = cmd_head.ctl;
          state_d = stripe_pkg::ST_MUX;
        end
      end

      stripe_pkg::ST_MUX: begin
        // Only the selected FIFO sees the stream
        fifo_tvalid[sel_q] = s_tvalid;
        s_tready           = fifo_tready[sel_q];

        if (tr_done) begin
          // Chain the next command with no idle cycle
          if (cmd_avail) begin
            cmd_pop = 1'b1;
            sel_d   = cmd_head.chan;
            cnt_d   = cmd_head.len;
            ctl_d   = cmd_head.ctl;
          end else begin
            state_d = stripe_pkg::ST_IDLE;
          end
        end else if (rxfer) begin
          // Next channel, wraps by overflow
          cnt_d = cnt_q - 1'b1;
          sel_d = sel_q + 1'b1;
        end
      end

      default: begin
        state_d = stripe_pkg::ST_IDLE;
      end
    endcase
  end

endmodule

//--- stripe_sink_top.f
stripe_pkg.sv
stripe_cmd_queue.sv
beat_fifo.sv
stripe_sink_mux.sv
stripe_sink_top.sv
tb_stripe_sink_top.sv

//--- stripe_sink_top.sv
// Striping sink top level
// Command queue, multiplexer and one beat FIFO per memory channel

`timescale 1ns/1ps

module stripe_sink_top #(
  parameter int CMD_DEPTH  = 8,
  parameter int FIFO_DEPTH = 16
) (
  input  logic                                       aclk,
  input  logic                                       aresetn,

  // Commands
  input  logic                                       cmd_push,
  input  stripe_pkg::stripe_cmd_t                    cmd_in,
  output logic                                       cmd_full,

  // User stream
  input  logic                                       s_tvalid,
  output logic                                       s_tready,
  input  stripe_pkg::beat_t                          s_beat,

  // Memory channel streams
  output logic [stripe_pkg::N_CHAN-1:0]              m_tvalid,
  input  logic [stripe_pkg::N_CHAN-1:0]              m_tready,
  output stripe_pkg::beat_t [stripe_pkg::N_CHAN-1:0] m_beat,

  // Completion
  output logic                                       done
);

  // ------------------------------------------------------------------
  // Internal wires
  // ------------------------------------------------------------------

  stripe_pkg::stripe_cmd_t cmd_head;
  logic                    cmd_avail;
  logic                    cmd_pop;

  logic [stripe_pkg::N_CHAN-1:0]              fifo_tvalid;
  logic [stripe_pkg::N_CHAN-1:0]              fifo_tready;
  stripe_pkg::beat_t [stripe_pkg::N_CHAN-1:0] fifo_beat;

  // Command queue
  stripe_cmd_queue #(
    .CMD_DEPTH (CMD_DEPTH)
  ) stripe_cmd_queue_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .cmd_push  (cmd_push),
    .cmd_in    (cmd_in),
    .cmd_pop   (cmd_pop),
    .cmd_head  (cmd_head),
    .cmd_avail (cmd_avail),
    .cmd_full  (cmd_full)
  );

  // Striping multiplexer
  stripe_sink_mux stripe_sink_mux_i (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .cmd_avail   (cmd_avail),
    .cmd_head    (cmd_head),
    .cmd_pop     (cmd_pop),
    .done        (done),
    .s_tvalid    (s_tvalid),
    .s_tready    (s_tready),
    .s_beat      (s_beat),
    .fifo_tvalid (fifo_tvalid),
    .fifo_tready (fifo_tready),
    .fifo_beat   (fifo_beat)
  );

  // One FIFO per channel
  for (genvar i = 0; i < stripe_pkg::N_CHAN; i++) begin : g_chan
    beat_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) beat_fifo_i (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .s_tvalid (fifo_tvalid[i]),
      .s_tready (fifo_tready[i]),
      .s_beat   (fifo_beat[i]),
      .m_tvalid (m_tvalid[i]),
      .m_tready (m_tready[i]),
      .m_beat   (m_beat[i])
    );
  end

endmodule

//--- tb_stripe_sink_top.sv
// Random testbench for the striping sink, checked against a beat-level model
// Run through the Makefile, ends with a pass or fail line

`timescale 1ns/1ps

module tb_stripe_sink_top;

  localparam int N_CMDS       = 200;
  localparam int CMD_DEPTH    = 8;
  localparam int FIFO_DEPTH   = 16;
  localparam int N_CHAN       = stripe_pkg::N_CHAN;
  localparam int VW           = $bits(stripe_pkg::beat_t);
  localparam int RESET_CYCLES = 5;
  localparam int QUIET_CYCLES = 12;
  localparam int STALL_CH     = 1;
  localparam int STALL_START  = 400;
  localparam int STALL_END    = 800;
  // Up to 16 beats per command at about six cycles each, plus reset and stall
  localparam int MAX_CYCLES   = N_CMDS * 16 * 6 + 800;

  logic                                       aclk = 1'b0;
  logic                                       aresetn;
  logic                                       cmd_push;
  stripe_pkg::stripe_cmd_t                    cmd_in;
  logic                                       cmd_full;
  logic                                       s_tvalid;
  logic                                       s_tready;
  stripe_pkg::beat_t                          s_beat;
  logic [N_CHAN-1:0]                          m_tvalid;
  logic [N_CHAN-1:0]                          m_tready;
  stripe_pkg::beat_t [N_CHAN-1:0]             m_beat;
  logic                                       done;

  // Stimulus state, written on the falling edge
  stripe_pkg::stripe_cmd_t cmds [N_CMDS];
  int   phase, drv_cycle, n_pushed, offered, total_beats, exp_ctl;
  int   push_gap, burst_left;
  logic stall_on;

  // Model state, written on the rising edge
  stripe_pkg::stripe_cmd_t model_cmds [$];
  stripe_pkg::beat_t       exp_q [N_CHAN][$];
  stripe_pkg::stripe_cmd_t cur_cmd;
  logic cur_active, in_xfer, stall_seen;
  int   cur_idx, cmds_done, done_seen, value_errs, other_errs, timeout_cnt;
  // Command queue occupancy and whether the mux holds a command
  int   q_cnt;
  logic mux_loaded;

  stripe_sink_top #(
    .CMD_DEPTH  (CMD_DEPTH),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) stripe_sink_top_i (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .cmd_push (cmd_push),
    .cmd_in   (cmd_in),
    .cmd_full (cmd_full),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_beat   (s_beat),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_beat   (m_beat),
    .done     (done)
  );

  initial begin
    forever #20 aclk = ~aclk;
  end

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------

  task automatic check_value(string name, logic [VW-1:0] got, logic [VW-1:0] exp);
    if (got !== exp) begin
      value_errs++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  function automatic stripe_pkg::beat_t make_beat();
    stripe_pkg::beat_t b;
    b.data = {$urandom, $urandom};
    b.keep = stripe_pkg::KEEP_BITS'($urandom);
    // Junk last, the DUT must overwrite it
    b.last = 1'($urandom);
    return b;
  endfunction

  function automatic bit all_drained();
    for (int i = 0; i < N_CHAN; i++) begin
      if (exp_q[i].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  // Commands in bursts separated by random gaps
  task automatic push_commands();
    cmd_push = 1'b0;
    if (n_pushed < N_CMDS) begin
      if (push_gap > 0) begin
        push_gap--;
      end else if (!cmd_full) begin
        cmd_push = 1'b1;
        cmd_in   = cmds[n_pushed];
        n_pushed++;
        if (burst_left > 0) begin
          burst_left--;
        end else begin
          burst_left = int'($urandom_range(0, 5));
          push_gap   = int'($urandom_range(0, 30));
        end
      end
    end
  endtask

  // Beat held until taken, then a new one or a gap
  task automatic offer_beats();
    if (!s_tvalid || in_xfer) begin
      if (offered < total_beats && $urandom_range(0, 3) != 0) begin
        s_beat   = make_beat();
        s_tvalid = 1'b1;
        offered++;
      end else begin
        s_tvalid = 1'b0;
      end
    end
  endtask

  // ------------------------------------------------------------------
  // Falling-edge driver
  // ------------------------------------------------------------------

  always @(negedge aclk) begin
    drv_cycle++;
    for (int i = 0; i < N_CHAN; i++) begin
      m_tready[i] = ($urandom_range(0, 9) < 6);
    end
    // One channel starved long enough to fill its FIFO
    stall_on = (drv_cycle >= STALL_START && drv_cycle < STALL_END);
    if (stall_on) m_tready[STALL_CH] = 1'b0;
    if (drv_cycle == RESET_CYCLES) begin
      aresetn = 1'b1;
      phase   = 1;
    end else if (drv_cycle == RESET_CYCLES + QUIET_CYCLES) begin
      phase = 2;
    end
    if (phase == 1 && !s_tvalid) begin
      // Stream offered with no command queued
      s_beat   = make_beat();
      s_tvalid = 1'b1;
      offered  = 1;
    end else if (phase == 2) begin
      push_commands();
      offer_beats();
    end
  end

  // ------------------------------------------------------------------
  // Rising-edge model and checks
  // ------------------------------------------------------------------

  always @(posedge aclk) begin
    stripe_pkg::beat_t exp_beat;
    int                tgt;
    logic              exp_done;
    logic              last_acc;
    logic              push_now;
    logic              pop_now;
    if (phase != 0) begin
      exp_done = 1'b0;
      last_acc = 1'b0;
      if (phase == 1) begin
        check_value("m_tvalid", VW'(m_tvalid), '0);
        check_value("s_tready", VW'(s_tready), '0);
      end
      // Next beat aimed at a full FIFO must stall the stream
      if (cur_active) begin
        tgt = (int'(cur_cmd.chan) + cur_idx) % N_CHAN;
        if (exp_q[tgt].size() == FIFO_DEPTH) begin
          check_value("s_tready", VW'(s_tready), '0);
          if (stall_on && tgt == STALL_CH && s_tvalid) stall_seen = 1'b1;
        end
      end
      // Beats leaving the channel FIFOs
      for (int i = 0; i < N_CHAN; i++) begin
        if (m_tvalid[i] && m_tready[i]) begin
          if (exp_q[i].size() == 0) begin
            other_errs++;
            $display("Error at %0t ns: beat on channel %0d with none expected", $time, i);
          end else begin
            exp_beat = exp_q[i].pop_front();
            check_value($sformatf("m_beat[%0d]", i), m_beat[i], exp_beat);
          end
        end
      end
      // Beat accepted from the user stream
      in_xfer = s_tvalid && s_tready;
      if (in_xfer && !cur_active) begin
        if (model_cmds.size() == 0) begin
          other_errs++;
          $display("Error at %0t ns: beat accepted with no command queued", $time);
        end else begin
          cur_cmd    = model_cmds.pop_front();
          cur_active = 1'b1;
          cur_idx    = 0;
        end
      end
      if (in_xfer && cur_active) begin
        tgt           = (int'(cur_cmd.chan) + cur_idx) % N_CHAN;
        exp_beat.data = s_beat.data;
        exp_beat.keep = s_beat.keep;
        exp_beat.last = (cur_idx == int'(cur_cmd.len));
        exp_q[tgt].push_back(exp_beat);
        if (exp_beat.last) begin
          cur_active = 1'b0;
          exp_done   = cur_cmd.ctl;
          last_acc   = 1'b1;
          cmds_done++;
        end else begin
          cur_idx++;
        end
      end
      check_value("done", VW'(done), VW'(exp_done));
      if (done) done_seen++;
      // Queue pops when the mux is idle or takes a final beat
      check_value("cmd_full", VW'(cmd_full), VW'(q_cnt == CMD_DEPTH));
      push_now = cmd_push && (q_cnt != CMD_DEPTH);
      pop_now  = (q_cnt != 0) && (!mux_loaded || last_acc);
      if (push_now) model_cmds.push_back(cmd_in);
      if (pop_now) begin
        mux_loaded = 1'b1;
      end else if (last_acc) begin
        mux_loaded = 1'b0;
      end
      q_cnt = q_cnt + int'(push_now) - int'(pop_now);
    end
  end

  always @(posedge aclk) begin
    timeout_cnt++;
    if (timeout_cnt >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, %0d of %0d commands done", timeout_cnt, cmds_done,
               N_CMDS);
      $display("** FAIL **");
      $finish;
    end
  end

  // ------------------------------------------------------------------
  // Setup and end of run
  // ------------------------------------------------------------------

  initial begin
    int unsigned seed_ret;
    seed_ret = $urandom(89);
    aresetn  = 1'b0;
    cmd_push = 1'b0;
    cmd_in   = '0;
    s_tvalid = 1'b0;
    s_beat   = '0;
    m_tready = '0;
    {phase, drv_cycle, n_pushed, offered, total_beats, exp_ctl} = '0;
    {push_gap, burst_left, cur_idx, cmds_done, done_seen} = '0;
    {value_errs, other_errs, timeout_cnt, q_cnt} = '0;
    {stall_on, cur_active, in_xfer, stall_seen, mux_loaded} = '0;
    cur_cmd = '0;
    for (int i = 0; i < N_CMDS; i++) begin
      cmds[i].chan = stripe_pkg::CHAN_BITS'($urandom_range(0, N_CHAN - 1));
      cmds[i].len  = stripe_pkg::LEN_BITS'($urandom_range(0, 15));
      cmds[i].ctl  = 1'($urandom_range(0, 1));
      total_beats += int'(cmds[i].len) + 1;
      exp_ctl     += int'(cmds[i].ctl);
    end
    // Every command retired and every channel drained
    do @(negedge aclk); while (cmds_done < N_CMDS || !all_drained());
    repeat (10) @(negedge aclk);
    check_value("done count", VW'(done_seen), VW'(exp_ctl));
    if (model_cmds.size() != 0) begin
      other_errs++;
      $display("Error: %0d pushed commands never received beats", model_cmds.size());
    end
    if (!stall_seen) begin
      other_errs++;
      $display("Error: a full channel FIFO never stalled the user stream");
    end
    $display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
